// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ========================================
// Datapath widths
// ========================================

// Data, address and instruction width
`define WORD_W 16
// Register select width
`define SEL_W 4
// ALU op code width
`define OP_W 4

// Reserved registers, hardwired in the register file
`define REG_ZERO 4'd0
`define REG_ONES 4'd1

// ALU op codes, in encoding order
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR 4'd3
`define ALU_XOR 4'd4
`define ALU_POPC 4'd5

// ========================================
// Instruction fields
// ========================================

// Class bits
`define OPC_TOP 15
`define OPC_MEM 14
`define OPC_ALU 13
// Function field, also rd of load-immediate
`define FN_HI 11
`define FN_LO 8
// Register fields
`define RD_HI 7
`define RD_LO 4
`define RS_HI 3
`define RS_LO 0
// Immediate of load-immediate
`define IMM_HI 7
`define IMM_LO 0

`endif

// File: logic/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	// ========================================
	// Datapath types
	// ========================================

	// Instruction, address or data word
	typedef logic [`WORD_W-1:0] word_t;

	// Register number, R0 and R1 are constants
	typedef logic [`SEL_W-1:0] reg_sel_t;

	// ALU operation code from the function field
	typedef logic [`OP_W-1:0] alu_op_t;

	// ========================================
	// Control types
	// ========================================

	// Fetch runs until a halt reaches the instruction register
	typedef enum logic {
		RUN,
		HALTED
	} fetch_state_t;

endpackage

// File: logic/issue_bus.sv
`timescale 1ns/1ns

// One decoded instruction per cycle, decode to execute
// No back-pressure, all enables low is a bubble
interface issue_bus
	import cpu_pkg::*;
();

	// ALU operation
	logic alu_en;
	alu_op_t alu_op;

	// Data memory access
	logic mem_ld;
	logic mem_st;

	// Register writeback target
	logic wb_en;
	reg_sel_t rd_sel;

	// Operands, rd_val carries the immediate for load-immediate
	word_t rd_val;
	word_t rs_val;

	// Decode side
	modport producer (
		output alu_en,
		output alu_op,
		output mem_ld,
		output mem_st,
		output wb_en,
		output rd_sel,
		output rd_val,
		output rs_val
	);

	// Execute side
	modport consumer (
		input alu_en,
		input alu_op,
		input mem_ld,
		input mem_st,
		input wb_en,
		input rd_sel,
		input rd_val,
		input rs_val
	);

endinterface

// File: logic/alu.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module alu
	import cpu_pkg::*;
(
	input word_t x,
	input word_t y,
	input alu_op_t op,
	output word_t z
);

	// Number of ones in a word
	function automatic word_t popcount(input word_t w);
		word_t cnt;
		cnt = '0;
		for (int i = 0; i < `WORD_W; i++)
			cnt = cnt + word_t'(w[i]);
		return cnt;
	endfunction

	// x is rd, y is rs
	always_comb begin
		case (op)
			`ALU_ADD: z = x + y;
			`ALU_SUB: z = x - y;
			`ALU_AND: z = x & y;
			`ALU_OR: z = x | y;
			`ALU_XOR: z = x ^ y;
			// Counts rs only
			`ALU_POPC: z = popcount(y);
			// Unused codes
			default: z = '0;
		endcase
	end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module fetch_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t code_mem_data,
	output word_t code_mem_addr,
	output word_t instr,
	output logic halt
);

	// Program counter and instruction register
	word_t pc;
	word_t ir;

	fetch_state_t state;

	// Halt word sitting in the instruction register
	logic is_halt;

	// Bits 15 to 9 clear, bit 8 set
	assign is_halt = ~|ir[`OPC_TOP:`FN_LO + 1] & ir[`FN_LO];

	// ========================================
	// PC, IR and halt FSM
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
			state <= RUN;
		end else begin
			case (state)
				RUN: begin
					// Halt in IR stops the PC, so the next word is never fetched
					if (is_halt) begin
						state <= HALTED;
					end else begin
						pc <= pc + word_t'(1);
						ir <= code_mem_data;
					end
				end
				// Frozen until reset
				default: state <= HALTED;
			endcase
		end
	end

	assign code_mem_addr = pc;
	assign instr = ir;
	assign halt = (state == HALTED);

	// PC stays at halt address plus one once halted
	pc_frozen_on_halt: assert property (@(posedge clk) disable iff (reset)
		halt |=> (pc == $past(pc)));

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module instr_decode
	import cpu_pkg::*;
(
	input word_t instr,
	output reg_sel_t rs_sel,
	output reg_sel_t rd_sel,
	input word_t rs_file,
	input word_t rd_file,
	input logic wb_en,
	input reg_sel_t wb_sel,
	input word_t wb_val,
	issue_bus.producer issue
);

	// Instruction classes
	logic is_alu;
	logic is_mem;
	logic is_ld;
	logic is_st;
	logic is_li;

	// Register values after forwarding
	word_t rs_fwd;
	word_t rd_fwd;

	// Sign-extended immediate
	word_t imm_val;

	// ========================================
	// Opcode decode
	// ========================================

	assign is_alu = ~instr[`OPC_TOP] & instr[`OPC_ALU];
	assign is_mem = ~instr[`OPC_TOP] & instr[`OPC_MEM];

	// Load has an all-zero function field
	assign is_ld = is_mem & ~|instr[`FN_HI:`FN_LO];

	// Store sets only the low function bit
	assign is_st = is_mem & ~|instr[`FN_HI:`FN_LO + 1] & instr[`FN_LO];

	assign is_li = instr[`OPC_TOP] & instr[`OPC_MEM];

	// Halt and unknown words leave every enable low
	assign issue.alu_en = is_alu;
	assign issue.alu_op = instr[`FN_HI:`FN_LO];
	assign issue.mem_ld = is_ld;
	assign issue.mem_st = is_st;
	assign issue.wb_en = is_alu | is_ld | is_li;

	// ========================================
	// Register selects
	// ========================================

	assign rs_sel = instr[`RS_HI:`RS_LO];

	// Load-immediate keeps rd in the function field
	assign rd_sel = is_li ? instr[`FN_HI:`FN_LO] : instr[`RD_HI:`RD_LO];

	assign issue.rd_sel = rd_sel;

	// ========================================
	// Operands
	// ========================================

	// Result written back this cycle bypasses the register file
	// wb_en is already masked for R0 and R1
	assign rs_fwd = (wb_en && wb_sel == rs_sel) ? wb_val : rs_file;
	assign rd_fwd = (wb_en && wb_sel == rd_sel) ? wb_val : rd_file;

	assign imm_val = {{(`WORD_W - `IMM_HI - 1){instr[`IMM_HI]}}, instr[`IMM_HI:`IMM_LO]};

	// Immediate travels in the rd slot
	assign issue.rd_val = is_li ? imm_val : rd_fwd;
	assign issue.rs_val = rs_fwd;

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module register_file
	import cpu_pkg::*;
(
	input logic clk,
	input reg_sel_t rs_sel,
	input reg_sel_t rd_sel,
	output word_t rs_file,
	output word_t rd_file,
	input logic wb_en,
	input reg_sel_t wb_sel,
	input word_t wb_val
);

	// Only R2 to R15 have storage
	word_t regs [2:15];

	// R0 reads zero, R1 reads all ones
	function automatic word_t read_reg(input reg_sel_t sel);
		if (sel == `REG_ZERO)
			return '0;
		else if (sel == `REG_ONES)
			return '1;
		else
			return regs[sel];
	endfunction

	assign rs_file = read_reg(rs_sel);
	assign rd_file = read_reg(rd_sel);

	always_ff @(posedge clk) begin
		if (wb_en)
			regs[wb_sel] <= wb_val;
	end

	// Execute drops writes to the constant registers
	no_const_write: assert property (@(posedge clk)
		wb_en |-> (wb_sel != `REG_ZERO && wb_sel != `REG_ONES));

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module execute_unit
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	issue_bus.consumer issue,
	output logic data_mem_write,
	output word_t data_mem_addr,
	output word_t data_mem_in,
	input word_t data_mem_out,
	output logic wb_en,
	output reg_sel_t wb_sel,
	output word_t wb_val
);

	// Stage register, control part
	logic ex_alu_en;
	alu_op_t ex_alu_op;
	logic ex_mem_ld;
	logic ex_mem_st;
	logic ex_wb_en;

	// Stage register, payload part
	reg_sel_t ex_rd_sel;
	word_t ex_rd_val;
	word_t ex_rs_val;

	word_t alu_z;

	// ========================================
	// Decode to execute stage register
	// ========================================

	// Cleared to a bubble on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_alu_en <= 1'b0;
			ex_alu_op <= '0;
			ex_mem_ld <= 1'b0;
			ex_mem_st <= 1'b0;
			ex_wb_en <= 1'b0;
		end else begin
			ex_alu_en <= issue.alu_en;
			ex_alu_op <= issue.alu_op;
			ex_mem_ld <= issue.mem_ld;
			ex_mem_st <= issue.mem_st;
			ex_wb_en <= issue.wb_en;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd_sel <= issue.rd_sel;
		ex_rd_val <= issue.rd_val;
		ex_rs_val <= issue.rs_val;
	end

	// Result is rd op rs
	alu u_alu (
		.x(ex_rd_val),
		.y(ex_rs_val),
		.op(ex_alu_op),
		.z(alu_z)
	);

	// Store addresses by rd, load by rs
	assign data_mem_write = ex_mem_st;
	assign data_mem_addr = ex_mem_st ? ex_rd_val : ex_rs_val;
	assign data_mem_in = ex_rs_val;

	// ========================================
	// Writeback
	// ========================================

	// Load data wins, then ALU, else rd_val (immediate)
	assign wb_val = ex_mem_ld ? data_mem_out : (ex_alu_en ? alu_z : ex_rd_val);
	assign wb_sel = ex_rd_sel;

	// R0 and R1 are never written
	assign wb_en = ex_wb_en && ex_rd_sel != `REG_ZERO && ex_rd_sel != `REG_ONES;

	// Decode never issues both accesses at once
	one_mem_access: assert property (@(posedge clk) disable iff (reset)
		!(ex_mem_ld && ex_mem_st));

endmodule

// File: logic/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
	import cpu_pkg::*;
(
	input logic clk,
	input logic reset,
	output word_t code_mem_addr,
	input word_t code_mem_data,
	output logic data_mem_write,
	output word_t data_mem_addr,
	output word_t data_mem_in,
	input word_t data_mem_out,
	output logic halt
);

	// Fetch to decode
	word_t instr;

	// Register file read ports
	reg_sel_t rs_sel;
	reg_sel_t rd_sel;
	word_t rs_file;
	word_t rd_file;

	// Writeback, also the forward path into decode
	logic wb_en;
	reg_sel_t wb_sel;
	word_t wb_val;

	// Decode to execute
	issue_bus issue_if ();

	fetch_unit u_fetch (
		.clk(clk),
		.reset(reset),
		.code_mem_data(code_mem_data),
		.code_mem_addr(code_mem_addr),
		.instr(instr),
		.halt(halt)
	);

	instr_decode u_decode (
		.instr(instr),
		.rs_sel(rs_sel),
		.rd_sel(rd_sel),
		.rs_file(rs_file),
		.rd_file(rd_file),
		.wb_en(wb_en),
		.wb_sel(wb_sel),
		.wb_val(wb_val),
		.issue(issue_if.producer)
	);

	register_file u_regs (
		.clk(clk),
		.rs_sel(rs_sel),
		.rd_sel(rd_sel),
		.rs_file(rs_file),
		.rd_file(rd_file),
		.wb_en(wb_en),
		.wb_sel(wb_sel),
		.wb_val(wb_val)
	);

	execute_unit u_exec (
		.clk(clk),
		.reset(reset),
		.issue(issue_if.consumer),
		.data_mem_write(data_mem_write),
		.data_mem_addr(data_mem_addr),
		.data_mem_in(data_mem_in),
		.data_mem_out(data_mem_out),
		.wb_en(wb_en),
		.wb_sel(wb_sel),
		.wb_val(wb_val)
	);

endmodule

// File: bench/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpu_tb
	import cpu_pkg::*;
();

	localparam int N_TESTS = 6;
	localparam int CLK_PERIOD = 100;
	localparam int MAX_WORDS = 8;
	localparam int MAX_STORES = 4;
	// Cycles allowed for halt to rise after reset
	localparam int HALT_WAIT = 20;
	// Cycles watched after halt for stray stores
	localparam int POST_HALT = 4;
	localparam word_t HALT_WORD = 16'h0100;

	logic clk;
	logic reset;
	word_t code_mem_addr;
	word_t code_mem_data;
	logic data_mem_write;
	word_t data_mem_addr;
	word_t data_mem_in;
	word_t data_mem_out;
	logic halt;

	// ========================================
	// Test table
	// ========================================

	string test_name [N_TESTS];
	word_t prog_tab [N_TESTS][MAX_WORDS];
	int prog_len [N_TESTS];
	word_t st_addr_tab [N_TESTS][MAX_STORES];
	word_t st_data_tab [N_TESTS][MAX_STORES];
	int st_cnt [N_TESTS];
	word_t halt_addr_tab [N_TESTS];

	// Run state
	int cur_row;
	int st_seen;
	int errors;

	cpu_top DUT (
		.clk(clk),
		.reset(reset),
		.code_mem_addr(code_mem_addr),
		.code_mem_data(code_mem_data),
		.data_mem_write(data_mem_write),
		.data_mem_addr(data_mem_addr),
		.data_mem_in(data_mem_in),
		.data_mem_out(data_mem_out),
		.halt(halt)
	);

	// Instruction encoders
	function automatic word_t alu_instr(input alu_op_t op, input reg_sel_t rd, input reg_sel_t rs);
		return {4'b0010, op, rd, rs};
	endfunction

	function automatic word_t load_instr(input reg_sel_t rd, input reg_sel_t rs);
		return {8'b0100_0000, rd, rs};
	endfunction

	function automatic word_t store_instr(input reg_sel_t rd, input reg_sel_t rs);
		return {8'b0100_0001, rd, rs};
	endfunction

	function automatic word_t li_instr(input reg_sel_t rd, input logic [7:0] imm);
		return {4'b1100, rd, imm};
	endfunction

	task automatic add_word(input int row, input word_t w);
		prog_tab[row][prog_len[row]] = w;
		prog_len[row]++;
	endtask

	task automatic expect_store(input int row, input word_t addr, input word_t data);
		st_addr_tab[row][st_cnt[row]] = addr;
		st_data_tab[row][st_cnt[row]] = data;
		st_cnt[row]++;
	endtask

	// Expected values follow the encoding rules by hand
	task automatic build_table();
		for (int r = 0; r < N_TESTS; r++) begin
			prog_len[r] = 0;
			st_cnt[r] = 0;
		end
		// Positive and negative immediates, address from rd
		test_name[0] = "li_store";
		add_word(0, li_instr(4'd2, 8'h35));
		add_word(0, li_instr(4'd3, 8'hF0));
		add_word(0, li_instr(4'd4, 8'h7F));
		add_word(0, store_instr(4'd2, 4'd3));
		add_word(0, store_instr(4'd3, 4'd4));
		add_word(0, store_instr(4'd4, 4'd2));
		expect_store(0, 16'h0035, 16'hFFF0);
		expect_store(0, 16'hFFF0, 16'h007F);
		expect_store(0, 16'h007F, 16'h0035);
		halt_addr_tab[0] = 16'd6;
		// Add, sub, and chained back to back
		test_name[1] = "alu_add_sub_and";
		add_word(1, li_instr(4'd2, 8'h5A));
		add_word(1, li_instr(4'd3, 8'hC3));
		add_word(1, alu_instr(`ALU_ADD, 4'd2, 4'd3));
		add_word(1, alu_instr(`ALU_SUB, 4'd3, 4'd2));
		add_word(1, alu_instr(`ALU_AND, 4'd2, 4'd3));
		add_word(1, store_instr(4'd0, 4'd2));
		add_word(1, store_instr(4'd1, 4'd3));
		expect_store(1, 16'h0000, 16'h0004);
		expect_store(1, 16'hFFFF, 16'hFFA6);
		halt_addr_tab[1] = 16'd7;
		// Or, pop-count, xor chained back to back
		test_name[2] = "alu_or_popc_xor";
		add_word(2, li_instr(4'd4, 8'h33));
		add_word(2, li_instr(4'd5, 8'h96));
		add_word(2, alu_instr(`ALU_OR, 4'd4, 4'd5));
		add_word(2, alu_instr(`ALU_POPC, 4'd6, 4'd4));
		add_word(2, alu_instr(`ALU_XOR, 4'd5, 4'd6));
		add_word(2, store_instr(4'd6, 4'd5));
		add_word(2, store_instr(4'd5, 4'd4));
		expect_store(2, 16'h000E, 16'hFF98);
		expect_store(2, 16'hFF98, 16'hFFB7);
		halt_addr_tab[2] = 16'd7;
		// Loaded value stored at once
		test_name[3] = "load_store";
		add_word(3, li_instr(4'd7, 8'h12));
		add_word(3, load_instr(4'd8, 4'd7));
		add_word(3, store_instr(4'd7, 4'd8));
		add_word(3, li_instr(4'd9, 8'h80));
		add_word(3, load_instr(4'd10, 4'd9));
		add_word(3, store_instr(4'd10, 4'd10));
		expect_store(3, 16'h0012, 16'hA5B7);
		expect_store(3, 16'h5A25, 16'h5A25);
		halt_addr_tab[3] = 16'd6;
		// Writes to R0 and R1 dropped, also on the forward path
		test_name[4] = "const_regs";
		add_word(4, li_instr(4'd2, 8'h20));
		add_word(4, li_instr(4'd0, 8'h55));
		add_word(4, store_instr(4'd2, 4'd0));
		add_word(4, li_instr(4'd1, 8'h00));
		add_word(4, store_instr(4'd0, 4'd1));
		add_word(4, alu_instr(`ALU_ADD, 4'd1, 4'd2));
		add_word(4, store_instr(4'd2, 4'd1));
		expect_store(4, 16'h0020, 16'h0000);
		expect_store(4, 16'h0000, 16'hFFFF);
		expect_store(4, 16'h0020, 16'hFFFF);
		halt_addr_tab[4] = 16'd7;
		// Stores after the halt word must never show
		test_name[5] = "halt";
		add_word(5, li_instr(4'd3, 8'h44));
		add_word(5, store_instr(4'd3, 4'd3));
		add_word(5, HALT_WORD);
		add_word(5, store_instr(4'd3, 4'd3));
		add_word(5, store_instr(4'd0, 4'd3));
		expect_store(5, 16'h0044, 16'h0044);
		halt_addr_tab[5] = 16'd2;
	endtask

	// ========================================
	// Checks
	// ========================================

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	// Compare one store strobe with the next expected pair
	task automatic record_store(input int row);
		if (st_seen >= st_cnt[row]) begin
			$display("unexpected extra store to 0x%h with data 0x%h", data_mem_addr, data_mem_in);
			errors++;
		end else begin
			check_word("data_mem_addr", data_mem_addr, st_addr_tab[row][st_seen]);
			check_word("data_mem_in", data_mem_in, st_data_tab[row][st_seen]);
		end
		st_seen++;
	endtask

	// Past the end of the program every word is a halt
	function automatic word_t fetch_word(input word_t addr);
		if (int'(addr) < prog_len[cur_row])
			return prog_tab[cur_row][addr[2:0]];
		return HALT_WORD;
	endfunction

	// ========================================
	// Clock, memories, watchdog
	// ========================================

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Memory models answer 5 ns after each rising edge
	initial begin
		code_mem_data = '0;
		data_mem_out = '0;
		forever begin
			@(posedge clk);
			#5;
			code_mem_data = fetch_word(code_mem_addr);
			data_mem_out = data_mem_addr ^ 16'hA5A5;
		end
	end

	initial begin
		#(N_TESTS * (8 + 8 + HALT_WAIT) * CLK_PERIOD);
		$display("timeout: the run did not finish in time");
		$display("** FAIL **");
		$finish;
	end

	// ========================================
	// Test loop
	// ========================================

	initial begin
		int errs_before;
		int passed;
		bit halt_seen;
		reset = 1'b1;
		cur_row = 0;
		errors = 0;
		passed = 0;
		build_table();
		for (int row = 0; row < N_TESTS; row++) begin
			errs_before = errors;
			@(posedge clk);
			#5;
			cur_row = row;
			reset = 1'b1;
			repeat (7) @(posedge clk);
			// State held in reset
			@(negedge clk);
			check_word("code_mem_addr", code_mem_addr, 16'h0000);
			check_flag("data_mem_write", data_mem_write, 1'b0);
			check_flag("halt", halt, 1'b0);
			@(posedge clk);
			#5;
			reset = 1'b0;
			st_seen = 0;
			halt_seen = 1'b0;
			for (int cyc = 0; cyc < HALT_WAIT && !halt_seen; cyc++) begin
				@(negedge clk);
				if (data_mem_write)
					record_store(row);
				if (halt)
					halt_seen = 1'b1;
			end
			if (!halt_seen) begin
				$display("halt did not rise within %0d cycles", HALT_WAIT);
				errors++;
			end else begin
				// Nothing may move once halted
				repeat (POST_HALT) begin
					@(negedge clk);
					if (data_mem_write)
						record_store(row);
				end
				check_flag("halt", halt, 1'b1);
				check_word("code_mem_addr", code_mem_addr, halt_addr_tab[row] + 16'd1);
			end
			if (st_seen < st_cnt[row]) begin
				$display("missing stores: saw %0d of %0d", st_seen, st_cnt[row]);
				errors++;
			end
			if (errors == errs_before) begin
				$display("test %0d %s: ok", row, test_name[row]);
				passed++;
			end else begin
				$display("test %0d %s: %0d errors", row, test_name[row], errors - errs_before);
			end
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			N_TESTS, passed, N_TESTS - passed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: compile.f
+incdir+logic
logic/cpu_pkg.sv
logic/issue_bus.sv
logic/alu.sv
logic/fetch_unit.sv
logic/instr_decode.sv
logic/register_file.sv
logic/execute_unit.sv
logic/cpu_top.sv
bench/cpu_tb.sv

// File: Makefile
# Verilator simulation of the CPU testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpu_tb
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

# Pass only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
